//--- attr_interp.f
+incdir+hdl
hdl/attr_interp_pkg.sv
hdl/plane_eval.sv
hdl/pipe_ctrl.sv
hdl/pixel_tracker.sv
hdl/attr_interp_top.sv
verif/attr_interp_tb.sv

//--- Makefile
# Verilator build for the attribute interpolator testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= attr_interp_tb
FLIST     ?= attr_interp.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/attr_interp_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the attribute interpolator
// Stimulus and m_ready change on the falling edge
// Outputs are sampled 1 ns before the rising edge
// Planes change only once the pipeline has drained
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "attr_interp_defines.svh"

module attr_interp_tb
    import attr_interp_pkg::*;
();

    localparam int RAND_PIXELS  = 400;
    localparam int TRI_COUNT    = 6;
    localparam int TRI_PIXELS   = 40;
    localparam int TOTAL_PIXELS = 1 + RAND_PIXELS + TRI_COUNT * TRI_PIXELS;
    localparam int CYCLE_LIMIT  = 20 * TOTAL_PIXELS + 200;

    typedef struct packed {
        logic       last;
        pixel_out_t pixel;
    } exp_beat_t;

    logic                           aclk = 1'b0;
    logic                           rst_n;
    logic                           s_valid;
    logic                           s_ready;
    logic                           s_last;
    pixel_in_t                      s_pixel;
    attr_plane_t [`NUM_ATTR-1:0]    planes;
    logic                           m_valid;
    logic                           m_ready;
    logic                           m_last;
    pixel_out_t                     m_pixel;
    logic                           pixel_in_pipeline;

    integer     seed;
    int         value_errors;
    int         other_errors;
    int         cycle;
    int         in_count;
    int         out_count;
    int         in_cycle;
    int         out_cycle;
    int         sent;
    logic       mon_en;
    logic       prev_busy;
    logic       ready_random;
    exp_beat_t  exp_q[$];

    always #5 aclk = ~aclk;

    attr_interp_top i_attr_interp_top (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .s_valid           (s_valid),
        .s_ready           (s_ready),
        .s_last            (s_last),
        .s_pixel           (s_pixel),
        .planes            (planes),
        .m_valid           (m_valid),
        .m_ready           (m_ready),
        .m_last            (m_last),
        .m_pixel           (m_pixel),
        .pixel_in_pipeline (pixel_in_pipeline)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random helpers and reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    // value = base + inc_x * x + inc_y * y modulo 2^32 with unsigned offsets
    function automatic logic [`ATTR_W-1:0] plane_value(attr_plane_t p,
                                                       logic [`POS_W-1:0] bx,
                                                       logic [`POS_W-1:0] by);
        logic [`ATTR_W-1:0] x;
        logic [`ATTR_W-1:0] y;
        x = {{(`ATTR_W - `POS_W){1'b0}}, bx};
        y = {{(`ATTR_W - `POS_W){1'b0}}, by};
        return p.base + p.inc_x * x + p.inc_y * y;
    endfunction

    function automatic exp_beat_t expect_beat(pixel_in_t px, logic last);
        exp_beat_t b;
        b.last       = last;
        b.pixel.side = px.side;
        for (int i = 0; i < `NUM_ATTR; i++) begin
            b.pixel.attr[i] = plane_value(planes[i], px.bbox_x, px.bbox_y);
        end
        return b;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_field(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("ERR at %0d ns: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic note_failure(string msg);
        other_errors++;
        $display("At %0d ns: %s", $time, msg);
    endtask

    task automatic check_idle();
        check_field("m_valid", 32'h0, 32'(m_valid));
        check_field("m_last", 32'h0, 32'(m_last));
        check_field("pixel_in_pipeline", 32'h0, 32'(pixel_in_pipeline));
        check_field("s_ready", 32'h1, 32'(s_ready));
    endtask

    task automatic compare_beat(exp_beat_t e);
        attr_id_e id;
        check_field("m_last", 32'(e.last), 32'(m_last));
        check_field("fb_index", e.pixel.side.fb_index, m_pixel.side.fb_index);
        check_field("screen_x", 32'(e.pixel.side.screen_x), 32'(m_pixel.side.screen_x));
        check_field("screen_y", 32'(e.pixel.side.screen_y), 32'(m_pixel.side.screen_y));
        for (int i = 0; i < `NUM_ATTR; i++) begin
            id = attr_id_e'(i);
            check_field(id.name(), e.pixel.attr[i], m_pixel.attr[i]);
        end
    endtask

    // Output side goes first since a pixel accepted now cannot leave at this edge
    task automatic sample_cycle();
        exp_beat_t e;
        check_field("pixel_in_pipeline", 32'(prev_busy), 32'(pixel_in_pipeline));
        if (m_valid === 1'b1 && m_ready === 1'b1) begin
            out_count++;
            out_cycle = cycle;
            if (exp_q.size() == 0) begin
                note_failure("Output beat arrived while no pixel was expected");
            end else begin
                e = exp_q.pop_front();
                compare_beat(e);
            end
        end
        if (s_valid === 1'b1 && s_ready === 1'b1) begin
            in_count++;
            in_cycle = cycle;
            exp_q.push_back(expect_beat(s_pixel, s_last));
        end
        prev_busy = (exp_q.size() != 0);
    endtask

    always begin
        @(negedge aclk);
        #4;
        cycle++;
        if (mon_en) begin
            sample_cycle();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(negedge aclk);
        if (ready_random) begin
            m_ready = (rand_below(100) >= 30);
        end else begin
            m_ready = 1'b1;
        end
    endtask

    // Wrap mode puts the base just below 2^32 and uses small signed increments
    task automatic randomize_planes(bit wrap);
        logic [31:0] r;
        for (int i = 0; i < `NUM_ATTR; i++) begin
            r = rand32();
            if (wrap) begin
                planes[i].base  = 32'hffff_ff00 + {24'b0, r[7:0]};
                r = rand32();
                planes[i].inc_x = {{20{r[11]}}, r[11:0]};
                planes[i].inc_y = {{20{r[27]}}, r[27:16]};
            end else begin
                planes[i].base  = r;
                planes[i].inc_x = rand32();
                planes[i].inc_y = rand32();
            end
        end
    endtask

    task automatic offer_pixel(logic last);
        logic [31:0] r;
        int          n;
        if (rand_below(10) < 3) begin
            s_valid = 1'b0;
            repeat (1 + rand_below(3)) next_cycle();
        end
        s_pixel.side.fb_index = rand32();
        r = rand32();
        s_pixel.side.screen_x = r[15:0];
        s_pixel.side.screen_y = r[31:16];
        r = rand32();
        s_pixel.bbox_x = r[15:0];
        s_pixel.bbox_y = r[31:16];
        s_last  = last;
        s_valid = 1'b1;
        n = in_count;
        // Hold the beat until the monitor has seen it transfer
        do begin
            next_cycle();
        end while (in_count == n);
        s_valid = 1'b0;
        sent++;
    endtask

    task automatic wait_drained();
        while (pixel_in_pipeline !== 1'b0 || exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    initial begin
        seed         = 32'ha875fcc7;
        value_errors = 0;
        other_errors = 0;
        cycle        = 0;
        in_count     = 0;
        out_count    = 0;
        in_cycle     = 0;
        out_cycle    = 0;
        sent         = 0;
        mon_en       = 1'b0;
        prev_busy    = 1'b0;
        ready_random = 1'b0;
        rst_n        = 1'b0;
        s_valid      = 1'b0;
        s_last       = 1'b0;
        s_pixel      = '0;
        m_ready      = 1'b1;
        randomize_planes(1'b0);

        next_cycle();
        check_idle();
        next_cycle();
        rst_n  = 1'b1;
        mon_en = 1'b1;
        next_cycle();
        check_idle();

        // Single pixel without back-pressure
        offer_pixel(1'b1);
        wait_drained();
        if (out_cycle - in_cycle != `PIPE_DEPTH) begin
            note_failure($sformatf("Single pixel took %0d cycles instead of %0d",
                                   out_cycle - in_cycle, `PIPE_DEPTH));
        end

        // Random stream with m_ready low about 30% of the time
        ready_random = 1'b1;
        for (int i = 0; i < RAND_PIXELS; i++) begin
            offer_pixel(i == RAND_PIXELS - 1);
        end
        wait_drained();

        // New triangle only after the previous one has left the pipeline
        for (int t = 0; t < TRI_COUNT; t++) begin
            wait_drained();
            randomize_planes(t[0] == 1'b0);
            for (int i = 0; i < TRI_PIXELS; i++) begin
                offer_pixel(i == TRI_PIXELS - 1);
            end
        end
        wait_drained();

        if (in_count != sent || out_count != sent) begin
            note_failure($sformatf("Sent %0d pixels but %0d were accepted and %0d delivered",
                                   sent, in_count, out_count));
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle < CYCLE_LIMIT) begin
            @(negedge aclk);
        end
        $display("Timeout after %0d cycles, the pixel stream did not complete", cycle);
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- hdl/attr_interp_top.sv
////////////////////////////////////////////////////////////////////////////
// Attribute interpolator, fixed point, 3-cycle latency when not stalled
// planes must not change while pixel_in_pipeline is high or s_valid is high
// The whole pipeline stalls while m_valid is high and m_ready is low
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "attr_interp_defines.svh"

module attr_interp_top
    import attr_interp_pkg::*;
(
    input  logic                            aclk,
    input  logic                            rst_n,

    // Pixel input stream
    input  logic                            s_valid,
    output logic                            s_ready,
    input  logic                            s_last,
    input  pixel_in_t                       s_pixel,

    // Per-triangle planes, indexed by attr_id_e
    input  attr_plane_t [`NUM_ATTR-1:0]     planes,

    // Interpolated pixel stream
    output logic                            m_valid,
    input  logic                            m_ready,
    output logic                            m_last,
    output pixel_out_t                      m_pixel,

    output logic                            pixel_in_pipeline
);

    logic                               advance;
    logic                               pixel_in;
    logic                               pixel_out;
    pixel_side_t                        m_side;
    logic [`NUM_ATTR-1:0][`ATTR_W-1:0]  attr_vals;

    assign pixel_in  = s_valid & s_ready;
    assign pixel_out = m_valid & m_ready;

    pipe_ctrl i_pipe_ctrl (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .s_valid (s_valid),
        .s_last  (s_last),
        .s_side  (s_pixel.side),
        .s_ready (s_ready),
        .m_ready (m_ready),
        .m_valid (m_valid),
        .m_last  (m_last),
        .m_side  (m_side),
        .advance (advance)
    );

    pixel_tracker i_pixel_tracker (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .pixel_in          (pixel_in),
        .pixel_out         (pixel_out),
        .pixel_in_pipeline (pixel_in_pipeline)
    );

    ////////////////////////////////////////////////////////////////////////////
    // One plane evaluator per attribute slot
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `NUM_ATTR; i++) begin : g_plane
        localparam attr_id_e SLOT = attr_id_e'(i);

        plane_eval i_plane_eval (
            .aclk    (aclk),
            .advance (advance),
            .bbox_x  (s_pixel.bbox_x),
            .bbox_y  (s_pixel.bbox_y),
            .plane   (planes[SLOT]),
            .value   (attr_vals[SLOT])
        );
    end

    assign m_pixel = '{side: m_side, attr: attr_vals};

endmodule

//--- hdl/pixel_tracker.sv
////////////////////////////////////////////////////////////////////////////
// Count of pixels accepted but not yet delivered
// pixel_in_pipeline follows a handshake by one cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "attr_interp_defines.svh"

module pixel_tracker
    import attr_interp_pkg::*;
(
    input  logic    aclk,
    input  logic    rst_n,
    input  logic    pixel_in,
    input  logic    pixel_out,
    output logic    pixel_in_pipeline
);

    logic [`TRACK_W-1:0] count_q;
    logic [`TRACK_W-1:0] count_next;

    // Simultaneous in and out leave the count unchanged
    always_comb begin
        count_next = count_q;
        if (pixel_in && !pixel_out) begin
            count_next = count_q + 1'b1;
        end else if (pixel_out && !pixel_in) begin
            count_next = count_q - 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            count_q           <= '0;
            pixel_in_pipeline <= 1'b0;
        end else begin
            count_q           <= count_next;
            pixel_in_pipeline <= (count_next != '0);
        end
    end

endmodule

//--- hdl/pipe_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Valid, last and sideband delay line with the pipeline stall logic
// Depth matches plane_eval, both move on the same advance
// s_ready depends combinationally on m_ready
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "attr_interp_defines.svh"

module pipe_ctrl
    import attr_interp_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_n,
    input  logic        s_valid,
    input  logic        s_last,
    input  pixel_side_t s_side,
    output logic        s_ready,
    input  logic        m_ready,
    output logic        m_valid,
    output logic        m_last,
    output pixel_side_t m_side,
    output logic        advance
);

    localparam int LAST_STAGE = `PIPE_DEPTH - 1;

    logic [`PIPE_DEPTH-1:0] valid_q;
    logic [`PIPE_DEPTH-1:0] last_q;
    pixel_side_t            side_q [`PIPE_DEPTH];

    // Whole pipeline holds while the output beat waits
    assign advance = ~(valid_q[LAST_STAGE] & ~m_ready);
    assign s_ready = advance;

    ////////////////////////////////////////////////////////////////////////////
    // Valid shift register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (advance) begin
            // An empty input slot enters as a bubble
            valid_q <= {valid_q[LAST_STAGE-1:0], s_valid};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Last and sideband shift register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (advance) begin
            last_q    <= {last_q[LAST_STAGE-1:0], s_last};
            side_q[0] <= s_side;
            for (int i = 1; i < `PIPE_DEPTH; i++) begin
                side_q[i] <= side_q[i-1];
            end
        end
    end

    assign m_valid = valid_q[LAST_STAGE];
    // Last only means something on a valid beat
    assign m_last  = valid_q[LAST_STAGE] & last_q[LAST_STAGE];
    assign m_side  = side_q[LAST_STAGE];

endmodule

//--- hdl/plane_eval.sv
////////////////////////////////////////////////////////////////////////////
// Pipelined evaluation of one attribute plane
// Result is valid 3 advancing edges after bbox_x and bbox_y are sampled
// The plane must stay constant while pixels of its triangle are in flight
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "attr_interp_defines.svh"

module plane_eval
    import attr_interp_pkg::*;
(
    input  logic                aclk,
    input  logic                advance,
    input  logic [`POS_W-1:0]   bbox_x,
    input  logic [`POS_W-1:0]   bbox_y,
    input  attr_plane_t         plane,
    output logic [`ATTR_W-1:0]  value
);

    // Offsets are unsigned, widened to the attribute width
    logic [`ATTR_W-1:0] off_x;
    logic [`ATTR_W-1:0] off_y;

    logic [`ATTR_W-1:0] prod_x_q;
    logic [`ATTR_W-1:0] prod_y_q;
    logic [`ATTR_W-1:0] sum_q;

    assign off_x = {{(`ATTR_W - `POS_W){1'b0}}, bbox_x};
    assign off_y = {{(`ATTR_W - `POS_W){1'b0}}, bbox_y};

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1: products, kept modulo 2^32
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (advance) begin
            prod_x_q <= off_x * plane.inc_x;
            prod_y_q <= off_y * plane.inc_y;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2: sum of both products
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (advance) begin
            sum_q <= prod_x_q + prod_y_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 3: add the base
    ////////////////////////////////////////////////////////////////////////////
    // Base is read here, two cycles after the offsets
    always_ff @(posedge aclk) begin
        if (advance) begin
            value <= sum_q + plane.base;
        end
    end

endmodule

//--- hdl/attr_interp_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Types shared by the attribute interpolator
// Increments are given at the same scale as the base, no shift applied
////////////////////////////////////////////////////////////////////////////

`include "attr_interp_defines.svh"

package attr_interp_pkg;

    // Slot of each attribute plane in the planes array and in the output
    typedef enum logic [2:0] {
        ATTR_DEPTH_Z,
        ATTR_COLOR_R,
        ATTR_COLOR_G,
        ATTR_COLOR_B,
        ATTR_COLOR_A
    } attr_id_e;

    // One plane: value = base + inc_x * bbox_x + inc_y * bbox_y
    typedef struct packed {
        logic [`ATTR_W-1:0] base;
        logic [`ATTR_W-1:0] inc_x;
        logic [`ATTR_W-1:0] inc_y;
    } attr_plane_t;

    // Fields passed through unchanged
    typedef struct packed {
        logic [`ATTR_W-1:0] fb_index;
        logic [`POS_W-1:0]  screen_y;
        logic [`POS_W-1:0]  screen_x;
    } pixel_side_t;

    // Incoming pixel with its bounding-box offset
    typedef struct packed {
        pixel_side_t        side;
        logic [`POS_W-1:0]  bbox_y;
        logic [`POS_W-1:0]  bbox_x;
    } pixel_in_t;

    // Outgoing pixel, attr indexed by attr_id_e
    typedef struct packed {
        pixel_side_t                        side;
        logic [`NUM_ATTR-1:0][`ATTR_W-1:0]  attr;
    } pixel_out_t;

endpackage

//--- hdl/attr_interp_defines.svh
////////////////////////////////////////////////////////////////////////////
// Width and depth constants for the attribute interpolator
// Attribute values are 32-bit two's-complement fixed point, modulo 2^32
// TRACK_W must hold PIPE_DEPTH plus one
////////////////////////////////////////////////////////////////////////////

`ifndef ATTR_INTERP_DEFINES_SVH
`define ATTR_INTERP_DEFINES_SVH

// Attribute value and coordinate widths
`define ATTR_W      32
`define POS_W       16

// Depth z plus four colour channels
`define NUM_ATTR    5

// Multiply, sum of products, add base
`define PIPE_DEPTH  3
`define TRACK_W     3

`endif
